//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// --------------------
// Datapath
// --------------------

// Data word and byte address width
`define CPU_WORD_W 16

// Architectural registers, r0 reads as zero
`define CPU_REG_CNT 16

// --------------------
// Unified memory
// --------------------

// Depth in 16-bit words
`define CPU_MEM_WORDS 256

// Word index width, taken from byte address bits 8 to 1
`define CPU_MEM_AW 8

`endif

//--- logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_sel_t;

	// Bit 2 is Z, bit 1 is V, bit 0 is N
	typedef logic [2:0] flags_t;

	typedef enum logic [1:0] {
		FLAG_N = 2'd0,
		FLAG_V = 2'd1,
		FLAG_Z = 2'd2
	} flag_idx_t;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_SLL, OP_SRA, OP_ROR, OP_OR,
		OP_LW, OP_SW, OP_LHB, OP_LLB, OP_B, OP_BR, OP_PCS, OP_HLT
	} opcode_t;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// --------------------
	// Pipeline registers
	// --------------------

	typedef struct packed {
		logic valid;
		word_t pc2;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc2;
		word_t instr;
		word_t op_a;
		word_t op_b;
		reg_sel_t rd_sel_1;
		reg_sel_t rd_sel_2;
		reg_sel_t dst;
		logic reg_write;
		logic mem_to_reg;
		logic mem_write;
	} id_ex_t;

	// halt marks an HLT travelling toward writeback
	typedef struct packed {
		logic valid;
		word_t result;
		word_t store_data;
		word_t addr;
		reg_sel_t dst;
		logic reg_write;
		logic mem_to_reg;
		logic mem_write;
		logic halt;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		logic reg_write;
		logic halt;
		reg_sel_t dst;
		word_t wr_data;
	} mem_wb_t;

	// --------------------
	// External ports
	// --------------------

	typedef struct packed {
		logic strobe;
		word_t addr;
		word_t data;
	} load_t;

	typedef struct packed {
		logic strobe;
		word_t addr;
		word_t data;
	} store_t;

	// Source registers of one instruction and whether each is really read
	typedef struct packed {
		logic use_1;
		logic use_2;
		reg_sel_t sel_1;
		reg_sel_t sel_2;
	} src_sel_t;

	// SW, LHB and LLB read their destination on port 1
	function automatic src_sel_t decode_src(word_t instr);
		src_sel_t s;
		opcode_t op;
		op = opcode_t'(instr[15:12]);
		s.sel_1 = (op inside {OP_SW, OP_LHB, OP_LLB}) ? instr[11:8] : instr[7:4];
		s.sel_2 = (op inside {OP_SW, OP_LW}) ? instr[7:4] : instr[3:0];
		s.use_1 = !(op inside {OP_LW, OP_B, OP_PCS, OP_HLT});
		s.use_2 = op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_LW, OP_SW};
		return s;
	endfunction

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
	input cpu_pkg::word_t a,
	input cpu_pkg::word_t b,
	input logic [2:0] op,
	output cpu_pkg::word_t result,
	output cpu_pkg::flags_t flags,
	output cpu_pkg::flags_t flag_we
);

	localparam int MSB = `CPU_WORD_W - 1;

	// Doubled operand so a right shift gives the rotate
	logic [2*`CPU_WORD_W-1:0] rot;
	logic ovf;

	always_comb begin
		rot = {a, a} >> b[3:0];
		ovf = 1'b0;
		flag_we = '0;
		// Every operation updates Z
		flag_we[cpu_pkg::FLAG_Z] = 1'b1;

		case (cpu_pkg::opcode_t'({1'b0, op}))
			cpu_pkg::OP_ADD: begin
				result = a + b;
				ovf = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
				flag_we = '1;
			end
			cpu_pkg::OP_SUB: begin
				result = a - b;
				ovf = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
				flag_we = '1;
			end
			cpu_pkg::OP_XOR: result = a ^ b;
			cpu_pkg::OP_AND: result = a & b;
			// Shift amount is the low nibble of b
			cpu_pkg::OP_SLL: result = a << b[3:0];
			cpu_pkg::OP_SRA: result = cpu_pkg::word_t'($signed(a) >>> b[3:0]);
			cpu_pkg::OP_ROR: result = rot[MSB:0];
			cpu_pkg::OP_OR: result = a | b;
			default: result = '0;
		endcase

		flags[cpu_pkg::FLAG_Z] = (result == '0);
		flags[cpu_pkg::FLAG_V] = ovf;
		flags[cpu_pkg::FLAG_N] = result[MSB];
	end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file #(
	parameter int WIDTH = `CPU_WORD_W
) (
	input logic clk,
	input logic rst,
	input cpu_pkg::reg_sel_t rd_sel_1,
	input cpu_pkg::reg_sel_t rd_sel_2,
	output logic [WIDTH-1:0] rd_data_1,
	output logic [WIDTH-1:0] rd_data_2,
	input logic wr_en,
	input cpu_pkg::reg_sel_t wr_sel,
	input logic [WIDTH-1:0] wr_data
);

	logic [WIDTH-1:0] regs [`CPU_REG_CNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_sel != '0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Write-first, the word being written wins over the stored one
	assign rd_data_1 = (rd_sel_1 == '0) ? '0 :
		(wr_en && wr_sel == rd_sel_1) ? wr_data : regs[rd_sel_1];
	assign rd_data_2 = (rd_sel_2 == '0) ? '0 :
		(wr_en && wr_sel == rd_sel_2) ? wr_data : regs[rd_sel_2];

endmodule

//--- logic/shared_mem.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module shared_mem (
	input logic clk,
	input cpu_pkg::load_t load,
	input cpu_pkg::word_t fetch_addr,
	output logic fetch_ok,
	output cpu_pkg::word_t fetch_data,
	input logic data_req,
	input logic data_we,
	input cpu_pkg::word_t data_addr,
	input cpu_pkg::word_t data_wdata,
	output cpu_pkg::word_t data_rdata
);

	cpu_pkg::word_t mem_array [`CPU_MEM_WORDS];

	logic data_go;
	logic [`CPU_MEM_AW-1:0] load_idx;
	logic [`CPU_MEM_AW-1:0] data_idx;
	logic [`CPU_MEM_AW-1:0] fetch_idx;
	logic [`CPU_MEM_AW-1:0] rd_idx;
	cpu_pkg::word_t rd_word;

	// --------------------
	// Priority grant
	// --------------------

	// Loader, then data, then fetch
	assign data_go = !load.strobe && data_req;
	assign fetch_ok = !load.strobe && !data_req;

	// Byte addresses, bit 0 ignored
	assign load_idx = load.addr[`CPU_MEM_AW:1];
	assign data_idx = data_addr[`CPU_MEM_AW:1];
	assign fetch_idx = fetch_addr[`CPU_MEM_AW:1];

	// --------------------
	// Single read port
	// --------------------

	assign rd_idx = data_go ? data_idx : fetch_idx;
	assign rd_word = mem_array[rd_idx];

	// Only the granted requester uses the word
	assign fetch_data = rd_word;
	assign data_rdata = rd_word;

	// --------------------
	// Write port
	// --------------------

	always_ff @(posedge clk) begin
		if (load.strobe) begin
			mem_array[load_idx] <= load.data;
		end else if (data_go && data_we) begin
			mem_array[data_idx] <= data_wdata;
		end
	end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input cpu_pkg::if_id_t id,
	input cpu_pkg::id_ex_t ex,
	input cpu_pkg::ex_mem_t mem,
	input cpu_pkg::mem_wb_t wb,
	output cpu_pkg::fwd_sel_t fwd_a,
	output cpu_pkg::fwd_sel_t fwd_b,
	output logic stall,
	output logic halting,
	output logic hlt_seen
);

	cpu_pkg::src_sel_t id_src;
	logic mem_fwd_ok;
	logic wb_fwd_ok;
	logic ex_is_load;
	logic id_hlt;
	logic ex_hlt;

	// Memory stage is younger, so it wins over writeback
	function automatic cpu_pkg::fwd_sel_t fwd_for(
		cpu_pkg::reg_sel_t src,
		logic mem_ok,
		cpu_pkg::reg_sel_t mem_dst,
		logic wb_ok,
		cpu_pkg::reg_sel_t wb_dst
	);
		if (mem_ok && mem_dst == src) begin
			return cpu_pkg::FWD_MEM;
		end
		if (wb_ok && wb_dst == src) begin
			return cpu_pkg::FWD_WB;
		end
		return cpu_pkg::FWD_NONE;
	endfunction

	// --------------------
	// Forwarding
	// --------------------

	// Writes to r0 are never forwarded
	assign mem_fwd_ok = mem.valid && mem.reg_write && mem.dst != '0;
	assign wb_fwd_ok = wb.valid && wb.reg_write && wb.dst != '0;

	assign fwd_a = fwd_for(ex.rd_sel_1, mem_fwd_ok, mem.dst, wb_fwd_ok, wb.dst);
	assign fwd_b = fwd_for(ex.rd_sel_2, mem_fwd_ok, mem.dst, wb_fwd_ok, wb.dst);

	// --------------------
	// Load-use stall
	// --------------------

	assign id_src = cpu_pkg::decode_src(id.instr);
	assign ex_is_load = ex.valid && ex.mem_to_reg && ex.dst != '0;

	assign stall = id.valid && ex_is_load &&
		((id_src.use_1 && id_src.sel_1 == ex.dst) ||
		(id_src.use_2 && id_src.sel_2 == ex.dst));

	// --------------------
	// Halt
	// --------------------

	assign id_hlt = id.valid && id.instr[15:12] == cpu_pkg::OP_HLT;
	assign ex_hlt = ex.valid && ex.instr[15:12] == cpu_pkg::OP_HLT;

	assign halting = id_hlt || ex_hlt || (mem.valid && mem.halt) || (wb.valid && wb.halt);
	assign hlt_seen = wb.valid && wb.halt;

endmodule

//--- logic/cpu.sv
`timescale 1ns/1ps

module cpu (
	input logic clk,
	input logic rst,
	input cpu_pkg::load_t load,
	output cpu_pkg::store_t store,
	output logic hlt,
	output cpu_pkg::word_t pc_out
);

	cpu_pkg::word_t pc;
	cpu_pkg::word_t pc_plus_2;
	cpu_pkg::if_id_t if_id;
	cpu_pkg::id_ex_t id_ex;
	cpu_pkg::ex_mem_t ex_mem;
	cpu_pkg::mem_wb_t mem_wb;
	cpu_pkg::flags_t flags;

	cpu_pkg::fwd_sel_t fwd_a;
	cpu_pkg::fwd_sel_t fwd_b;
	logic stall;
	logic halting;
	logic hlt_seen;
	logic freeze;

	cpu_pkg::load_t mem_load;
	logic fetch_ok;
	cpu_pkg::word_t fetch_data;

	cpu_pkg::opcode_t id_op;
	cpu_pkg::src_sel_t id_src;
	cpu_pkg::word_t rd_data_1;
	cpu_pkg::word_t rd_data_2;
	cpu_pkg::id_ex_t id_ex_d;

	cpu_pkg::opcode_t ex_op;
	cpu_pkg::word_t ex_a;
	cpu_pkg::word_t ex_b;
	cpu_pkg::word_t alu_b;
	cpu_pkg::word_t alu_result;
	cpu_pkg::word_t ex_result;
	cpu_pkg::word_t ex_addr;
	cpu_pkg::word_t br_target;
	cpu_pkg::flags_t alu_flags;
	cpu_pkg::flags_t alu_flag_we;
	logic br_cond;
	logic redirect;

	logic data_req;
	logic mem_we;
	cpu_pkg::word_t data_rdata;
	cpu_pkg::word_t mem_wr_data;

	// --------------------
	// Fetch
	// --------------------

	assign pc_plus_2 = pc + cpu_pkg::word_t'(2);
	assign freeze = halting || hlt;

	// Program loading only while in reset
	always_comb begin
		mem_load = load;
		mem_load.strobe = load.strobe && rst;
	end

	shared_mem u_mem (
		.clk(clk),
		.load(mem_load),
		.fetch_addr(pc),
		.fetch_ok(fetch_ok),
		.fetch_data(fetch_data),
		.data_req(data_req),
		.data_we(mem_we),
		.data_addr(ex_mem.addr),
		.data_wdata(ex_mem.store_data),
		.data_rdata(data_rdata)
	);

	// --------------------
	// Decode
	// --------------------

	assign id_op = cpu_pkg::opcode_t'(if_id.instr[15:12]);
	assign id_src = cpu_pkg::decode_src(if_id.instr);

	reg_file #(
		.WIDTH($bits(cpu_pkg::word_t))
	) u_regs (
		.clk(clk),
		.rst(rst),
		.rd_sel_1(id_src.sel_1),
		.rd_sel_2(id_src.sel_2),
		.rd_data_1(rd_data_1),
		.rd_data_2(rd_data_2),
		.wr_en(mem_wb.valid && mem_wb.reg_write),
		.wr_sel(mem_wb.dst),
		.wr_data(mem_wb.wr_data)
	);

	always_comb begin
		id_ex_d.valid = if_id.valid;
		id_ex_d.pc2 = if_id.pc2;
		id_ex_d.instr = if_id.instr;
		id_ex_d.op_a = rd_data_1;
		id_ex_d.op_b = rd_data_2;
		id_ex_d.rd_sel_1 = id_src.sel_1;
		id_ex_d.rd_sel_2 = id_src.sel_2;
		id_ex_d.dst = if_id.instr[11:8];
		// ALU ops, LW, LHB, LLB and PCS write a register
		id_ex_d.reg_write = if_id.valid && (!if_id.instr[15] ||
			id_op inside {cpu_pkg::OP_LW, cpu_pkg::OP_LHB, cpu_pkg::OP_LLB, cpu_pkg::OP_PCS});
		id_ex_d.mem_to_reg = if_id.valid && id_op == cpu_pkg::OP_LW;
		id_ex_d.mem_write = if_id.valid && id_op == cpu_pkg::OP_SW;
	end

	// --------------------
	// Execute
	// --------------------

	assign ex_op = cpu_pkg::opcode_t'(id_ex.instr[15:12]);

	always_comb begin
		case (fwd_a)
			cpu_pkg::FWD_MEM: ex_a = mem_wr_data;
			cpu_pkg::FWD_WB: ex_a = mem_wb.wr_data;
			default: ex_a = id_ex.op_a;
		endcase
		case (fwd_b)
			cpu_pkg::FWD_MEM: ex_b = mem_wr_data;
			cpu_pkg::FWD_WB: ex_b = mem_wb.wr_data;
			default: ex_b = id_ex.op_b;
		endcase
	end

	// Shifts take their amount from the immediate nibble
	assign alu_b = (ex_op inside {cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR}) ?
		cpu_pkg::word_t'(id_ex.instr[3:0]) : ex_b;

	alu u_alu (
		.a(ex_a),
		.b(alu_b),
		.op(id_ex.instr[14:12]),
		.result(alu_result),
		.flags(alu_flags),
		.flag_we(alu_flag_we)
	);

	always_comb begin
		case (ex_op)
			cpu_pkg::OP_LHB: ex_result = {id_ex.instr[7:0], ex_a[7:0]};
			cpu_pkg::OP_LLB: ex_result = {ex_a[15:8], id_ex.instr[7:0]};
			cpu_pkg::OP_PCS: ex_result = id_ex.pc2;
			default: ex_result = alu_result;
		endcase
	end

	// Word-aligned base plus doubled signed offset
	assign ex_addr = (ex_b & ~cpu_pkg::word_t'(1)) +
		{{11{id_ex.instr[3]}}, id_ex.instr[3:0], 1'b0};

	// Condition codes over the stored flags
	always_comb begin
		case (id_ex.instr[11:9])
			3'd0: br_cond = !flags[cpu_pkg::FLAG_Z];
			3'd1: br_cond = flags[cpu_pkg::FLAG_Z];
			3'd2: br_cond = !flags[cpu_pkg::FLAG_Z] && !flags[cpu_pkg::FLAG_N];
			3'd3: br_cond = flags[cpu_pkg::FLAG_N];
			3'd4: br_cond = flags[cpu_pkg::FLAG_Z] || !flags[cpu_pkg::FLAG_N];
			3'd5: br_cond = flags[cpu_pkg::FLAG_N] || flags[cpu_pkg::FLAG_Z];
			3'd6: br_cond = flags[cpu_pkg::FLAG_V];
			default: br_cond = 1'b1;
		endcase
	end

	assign br_target = (ex_op == cpu_pkg::OP_BR) ? ex_a :
		id_ex.pc2 + {{6{id_ex.instr[8]}}, id_ex.instr[8:0], 1'b0};
	assign redirect = id_ex.valid && br_cond &&
		(ex_op == cpu_pkg::OP_B || ex_op == cpu_pkg::OP_BR);

	// --------------------
	// Memory
	// --------------------

	assign data_req = ex_mem.valid && (ex_mem.mem_to_reg || ex_mem.mem_write);
	assign mem_we = ex_mem.valid && ex_mem.mem_write;
	assign mem_wr_data = ex_mem.mem_to_reg ? data_rdata : ex_mem.result;

	assign store = '{strobe: mem_we, addr: ex_mem.addr, data: ex_mem.store_data};

	hazard_unit u_hazard (
		.id(if_id),
		.ex(id_ex),
		.mem(ex_mem),
		.wb(mem_wb),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.stall(stall),
		.halting(halting),
		.hlt_seen(hlt_seen)
	);

	// --------------------
	// State
	// --------------------

	// Redirect beats stall, stall beats a frozen or lost fetch
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			if_id.valid <= 1'b0;
			id_ex.valid <= 1'b0;
		end else if (redirect) begin
			pc <= br_target;
			if_id.valid <= 1'b0;
			id_ex.valid <= 1'b0;
		end else if (stall) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex <= id_ex_d;
			if (!freeze && fetch_ok) begin
				pc <= pc_plus_2;
				if_id <= '{valid: 1'b1, pc2: pc_plus_2, instr: fetch_data};
			end else begin
				if_id.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_mem.valid <= 1'b0;
			mem_wb.valid <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.result <= ex_result;
			ex_mem.store_data <= ex_a;
			ex_mem.addr <= ex_addr;
			ex_mem.dst <= id_ex.dst;
			ex_mem.reg_write <= id_ex.reg_write;
			ex_mem.mem_to_reg <= id_ex.mem_to_reg;
			ex_mem.mem_write <= id_ex.mem_write;
			ex_mem.halt <= ex_op == cpu_pkg::OP_HLT;
			mem_wb <= '{valid: ex_mem.valid, reg_write: ex_mem.reg_write,
				halt: ex_mem.halt, dst: ex_mem.dst, wr_data: mem_wr_data};
		end
	end

	// Flags follow ALU ops only, per-flag enables
	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
			hlt <= 1'b0;
		end else begin
			if (id_ex.valid && !id_ex.instr[15]) begin
				flags <= (flags & ~alu_flag_we) | (alu_flags & alu_flag_we);
			end
			if (hlt_seen) begin
				hlt <= 1'b1;
			end
		end
	end

	assign pc_out = pc;

endmodule

//--- testbench/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input logic clk,
	input logic rst,
	input cpu_pkg::store_t store,
	input logic hlt,
	input cpu_pkg::word_t pc_out
);

	// Pipeline is cleared one edge into reset
	store_quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !store.strobe)
		else $error("store strobe high during reset");

	hlt_is_sticky: assert property (@(posedge clk)
		hlt && !rst |=> hlt || rst)
		else $error("hlt fell without reset");

	store_addr_even: assert property (@(posedge clk) disable iff (rst)
		store.strobe |-> !store.addr[0])
		else $error("odd store address");

	// Halted PC stays put
	pc_frozen_in_halt: assert property (@(posedge clk) disable iff (rst)
		hlt && $past(hlt) |-> $stable(pc_out))
		else $error("pc_out moved while halted");

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

	localparam int N_TESTS = 4;
	localparam int MAX_PROG = 180;
	localparam int LIMIT = N_TESTS * (MAX_PROG * 40 + `CPU_MEM_WORDS + 16);

	logic clk;
	logic rst;
	cpu_pkg::load_t load;
	cpu_pkg::store_t store;
	logic hlt;
	cpu_pkg::word_t pc_out;

	cpu_pkg::word_t image [`CPU_MEM_WORDS];
	cpu_pkg::store_t exp_stores [$];
	int prog_len;
	int errors = 0;
	string cur_test = "reset";
	logic [31:0] rng = 32'd84210;

	cpu u_dut (
		.clk(clk),
		.rst(rst),
		.load(load),
		.store(store),
		.hlt(hlt),
		.pc_out(pc_out)
	);

	bind cpu cpu_checker u_checker (
		.clk(clk),
		.rst(rst),
		.store(store),
		.hlt(hlt),
		.pc_out(pc_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		errors++;
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_store(input string name, input cpu_pkg::store_t exp,
		input cpu_pkg::store_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s store expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic compare_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		if (act !== exp) begin
			abort_run($sformatf("MISMATCH %s word expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic logic [31:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [3:0] rand_reg();
		return 4'(1 + xorshift() % 12);
	endfunction

	// --------------------
	// Program building
	// --------------------

	function automatic cpu_pkg::word_t instr_word(input logic [3:0] op, f2, f1, f0);
		return {op, f2, f1, f0};
	endfunction

	function automatic cpu_pkg::word_t imm_word(input logic [3:0] op, rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic emit(input cpu_pkg::word_t w);
		image[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_const(input logic [3:0] rd, input cpu_pkg::word_t v);
		emit(imm_word(4'hB, rd, v[7:0]));
		emit(imm_word(4'hA, rd, v[15:8]));
	endtask

	// Fill pattern depends on every address bit
	task automatic begin_program();
		for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
			image[i] = cpu_pkg::word_t'(i * 40503) ^ 16'h3C5A;
		end
		prog_len = 0;
		// r15 is an odd data base so bit 0 must be masked off
		load_const(4'd15, 16'h0181);
		for (int r = 1; r <= 12; r++) begin
			load_const(4'(r), cpu_pkg::word_t'(xorshift()));
		end
	endtask

	task automatic random_alu(inout logic [3:0] last);
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		op = 4'(xorshift() % 8);
		rd = rand_reg();
		rs = (xorshift() % 2 == 1) ? last : 4'(xorshift());
		rt = (xorshift() % 2 == 1) ? last : 4'(xorshift());
		emit(instr_word(op, rd, rs, rt));
		last = rd;
	endtask

	task automatic store_regs();
		for (int r = 1; r <= 12; r++) begin
			emit(instr_word(4'h9, 4'(r), 4'd15, 4'(r - 6)));
		end
	endtask

	task automatic build_program(input int kind);
		logic [3:0] last;
		logic [3:0] y;
		cpu_pkg::word_t target;
		begin_program();
		last = 4'd1;
		case (kind)
			0: begin
				repeat (50) random_alu(last);
			end
			1: begin
				// Store, reload, use at once, store the reloaded value
				repeat (12) begin
					y = rand_reg();
					emit(instr_word(4'h9, last, 4'd15, 4'(xorshift())));
					emit(instr_word(4'h8, y, 4'd15, 4'(xorshift())));
					emit(instr_word(4'h0, rand_reg(), y, last));
					emit(instr_word(4'h9, y, 4'd15, 4'(xorshift())));
					random_alu(last);
				end
			end
			2: begin
				for (int c = 0; c < 16; c++) begin
					if (c % 3 == 0) begin
						emit(instr_word(4'h1, last, last, last));
					end else begin
						random_alu(last);
					end
					emit({4'hC, 3'(c), 9'd2});
					emit(instr_word(4'h9, 4'd1, 4'd15, 4'(xorshift())));
					emit(instr_word(4'h9, 4'd2, 4'd15, 4'(xorshift())));
				end
				random_alu(last);
				target = cpu_pkg::word_t'((prog_len + 5) * 2);
				load_const(4'd13, target);
				emit({4'hD, 3'(xorshift()), 1'b0, 4'd13, 4'h0});
				emit(instr_word(4'h9, 4'd3, 4'd15, 4'd7));
				emit(instr_word(4'h9, 4'd4, 4'd15, 4'd6));
				emit(instr_word(4'hE, 4'd14, 4'd0, 4'd0));
				emit(instr_word(4'h9, 4'd14, 4'd15, 4'd0));
			end
			default: begin
				repeat (6) random_alu(last);
				// HLT in the shadow of an always-taken branch
				emit({4'hC, 3'd7, 9'd2});
				emit(16'hF000);
				emit(instr_word(4'h9, 4'd5, 4'd15, 4'd1));
			end
		endcase
		store_regs();
		emit(16'hF000);
		emit(instr_word(4'h9, 4'd1, 4'd15, 4'd0));
		emit(instr_word(4'h9, 4'd2, 4'd15, 4'd1));
		if (prog_len > MAX_PROG) begin
			abort_run("generated program overlaps the data region");
		end
	endtask

	// --------------------
	// Reference model
	// --------------------

	function automatic logic cond_met(input logic [2:0] code, input logic z, v, n);
		case (code)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return n || z;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	function automatic cpu_pkg::word_t ref_run();
		cpu_pkg::word_t m [`CPU_MEM_WORDS];
		cpu_pkg::word_t r [`CPU_REG_CNT];
		cpu_pkg::word_t pc;
		cpu_pkg::word_t ins;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t res;
		cpu_pkg::word_t addr;
		logic [3:0] sh;
		logic [3:0] d;
		logic z;
		logic v;
		logic n;
		exp_stores.delete();
		for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
			m[i] = image[i];
		end
		for (int i = 0; i < `CPU_REG_CNT; i++) begin
			r[i] = '0;
		end
		{pc, z, v, n} = '0;
		for (int step = 0; step < 4096; step++) begin
			ins = m[pc[8:1]];
			d = ins[11:8];
			sh = ins[3:0];
			a = r[ins[7:4]];
			b = r[ins[3:0]];
			addr = (a & 16'hFFFE) + {{11{ins[3]}}, ins[3:0], 1'b0};
			if (ins[15:12] == 4'hF) begin
				return pc;
			end
			pc = pc + 16'd2;
			case (cpu_pkg::opcode_t'(ins[15:12]))
				cpu_pkg::OP_ADD: begin
					res = a + b;
					v = (a[15] == b[15]) && (res[15] != a[15]);
				end
				cpu_pkg::OP_SUB: begin
					res = a - b;
					v = (a[15] != b[15]) && (res[15] != a[15]);
				end
				cpu_pkg::OP_XOR: res = a ^ b;
				cpu_pkg::OP_AND: res = a & b;
				cpu_pkg::OP_SLL: res = a << sh;
				cpu_pkg::OP_SRA: res = $signed(a) >>> sh;
				cpu_pkg::OP_ROR: res = (a >> sh) | (a << (16 - sh));
				cpu_pkg::OP_OR: res = a | b;
				cpu_pkg::OP_LW: r[d] = m[addr[8:1]];
				cpu_pkg::OP_SW: begin
					m[addr[8:1]] = r[d];
					exp_stores.push_back('{strobe: 1'b1, addr: addr, data: r[d]});
				end
				cpu_pkg::OP_LHB: r[d] = {ins[7:0], r[d][7:0]};
				cpu_pkg::OP_LLB: r[d] = {r[d][15:8], ins[7:0]};
				cpu_pkg::OP_B: begin
					if (cond_met(ins[11:9], z, v, n)) begin
						pc = pc + {{6{ins[8]}}, ins[8:0], 1'b0};
					end
				end
				cpu_pkg::OP_BR: begin
					if (cond_met(ins[11:9], z, v, n)) begin
						pc = a;
					end
				end
				default: r[d] = pc;
			endcase
			if (!ins[15]) begin
				r[d] = res;
				z = (res == 16'd0);
				if (ins[15:13] == 3'b000) begin
					n = res[15];
				end
			end
			r[0] = '0;
		end
		return 16'hFFFF;
	endfunction

	// --------------------
	// Run control
	// --------------------

	task automatic reset_and_load();
		@(posedge clk);
		#1 rst = 1'b1;
		load = '0;
		repeat (4) @(posedge clk);
		for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
			#1 load = '{strobe: 1'b1, addr: cpu_pkg::word_t'(i * 2), data: image[i]};
			@(posedge clk);
		end
		#1 load = '0;
		rst = 1'b0;
	endtask

	task automatic run_test(input string name, input int kind);
		cpu_pkg::word_t halt_addr;
		build_program(kind);
		halt_addr = ref_run();
		reset_and_load();
		cur_test = name;
		if (hlt !== 1'b0 || store.strobe !== 1'b0) begin
			abort_run($sformatf("%s: hlt or store strobe not low after reset", name));
		end
		compare_word({name, " reset pc"}, 16'd0, pc_out);
		while (hlt !== 1'b1) @(posedge clk);
		// Quiet window after halt
		repeat (6) @(posedge clk);
		if (exp_stores.size() != 0) begin
			abort_run($sformatf("%s: %0d expected stores never happened", name,
				exp_stores.size()));
		end
		compare_word({name, " halt pc"}, halt_addr + 16'd2, pc_out);
	endtask

	// Store strobes checked in order at mid-cycle
	always @(negedge clk) begin
		cpu_pkg::store_t exp;
		if (!rst && store.strobe === 1'b1) begin
			if (exp_stores.size() == 0) begin
				abort_run($sformatf("%s: unexpected store to %h", cur_test, store.addr));
			end else begin
				exp = exp_stores.pop_front();
				compare_store(cur_test, exp, store);
			end
		end
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		abort_run("timeout: processor never reached halt");
	end

	initial begin
		rst = 1'b1;
		load = '0;
		run_test("alu_chain", 0);
		run_test("load_use", 1);
		run_test("branches", 2);
		run_test("halt", 3);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+logic
logic/cpu_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/shared_mem.sv
logic/hazard_unit.sv
logic/cpu.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - logic/shared_mem.sv
      - logic/hazard_unit.sv
      - logic/cpu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/cpu_checker.sv
      - testbench/cpu_tb.sv
